// ==== swu_trace.txt ====
// i <data hex>: one input word, the 32 words of frame 1 come first, then frame 2
// e <output index> <data hex>: expected output word, index counts over both frames
i 1000
i 1001
i 1002
i 1003
i 1004
i 1005
i 1006
i 1007
i 1008
i 1009
i 100A
i 100B
i 100C
i 100D
i 100E
i 100F
i 1010
i 1011
i 1012
i 1013
i 1014
i 1015
i 1016
i 1017
i 1018
i 1019
i 101A
i 101B
i 101C
i 101D
i 101E
i 101F
i 2000
i 2011
i 2022
i 2033
i 2044
i 2055
i 2066
i 2077
i 2088
i 2099
i 20AA
i 20BB
i 20CC
i 20DD
i 20EE
i 20FF
i 2110
i 2121
i 2132
i 2143
i 2154
i 2165
i 2176
i 2187
i 2198
i 21A9
i 21BA
i 21CB
i 21DC
i 21ED
i 21FE
i 220F
e 0 0000
e 8 1000
e 9 1001
e 17 100B
e 100 100C
e 270 1014
e 287 0000
e 296 2000
e 305 20BB
e 388 20CC
e 558 2154
e 575 0000

// ==== flist.f ====
swu_pkg.sv
window_buffer.sv
window_addr_gen.sv
window_out_stage.sv
sliding_window_unit.sv
tb_sliding_window_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sliding_window_unit
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_sliding_window_unit.sv ====
module tb_sliding_window_unit
   import swu_pkg::*;
();

   logic      clk;
   logic      resetn;
   logic      in_valid_i;
   logic      in_ready_o;
   word_t     in_data_i;
   logic      out_valid_o;
   logic      out_ready_i;
   out_word_t out_word_o;

   // input words of both frames and checkpoints keyed by output index
   word_t in_words [$];
   word_t chk_word [int];

   sliding_window_unit sliding_window_unit_inst (
      .clk         (clk),
      .resetn      (resetn),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .in_data_i   (in_data_i),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i),
      .out_word_o  (out_word_o)
   );

   always #20 clk = ~clk;

   ////////////////////////////////////////
   // checks and reporting
   ////////////////////////////////////////
   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
         $display("** FAIL **");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic report_timeout(input string cause);
      $display("Timeout: %s", cause);
      $display("** FAIL **");
      $fatal(1, "run stopped on timeout");
   endtask

   task automatic load_trace();
      int          fd;
      int          idx;
      logic [31:0] word;
      string       line;
      fd = $fopen("swu_trace.txt", "r");
      if (fd == 0) begin
         $display("Could not open the trace file swu_trace.txt");
         $display("** FAIL **");
         $fatal(1, "trace file missing");
      end
      while ($fgets(line, fd) != 0) begin
         if ($sscanf(line, "i %h", word) == 1) begin
            in_words.push_back(word[WORD_W-1:0]);
         end else if ($sscanf(line, "e %d %h", idx, word) == 2) begin
            chk_word[idx] = word[WORD_W-1:0];
         end
      end
      $fclose(fd);
   endtask

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////

   // input index behind output word k of a frame or -1 for a padded position
   function automatic int source_index(input int k);
      int ch;
      int kw;
      int kh;
      int ox;
      int oy;
      int row;
      int col;
      ch  = k % CH_FOLDS;
      kw  = (k / CH_FOLDS) % K_W;
      kh  = (k / (CH_FOLDS * K_W)) % K_H;
      ox  = (k / (CH_FOLDS * K_W * K_H)) % OFM_W;
      oy  = k / (CH_FOLDS * K_W * K_H * OFM_W);
      row = oy * STRIDE + kh - PAD;
      col = ox * STRIDE + kw - PAD;
      if (row < 0 || row >= IFM_H || col < 0 || col >= IFM_W) begin
         return -1;
      end
      return (row * IFM_W + col) * CH_FOLDS + ch;
   endfunction

   ////////////////////////////////////////
   // stream drivers
   ////////////////////////////////////////
   task automatic drive_frame(input int set, input bit gaps);
      int sent;
      int idle;
      sent = 0;
      idle = 0;
      while (sent < FRAME_IN_WORDS) begin
         @(posedge clk);
         if (in_valid_i && in_ready_o) begin
            sent++;
            idle = 0;
         end else begin
            idle++;
         end
         if (idle > 1000) begin
            report_timeout("input words of the frame were not accepted");
         end
         if (sent == FRAME_IN_WORDS) begin
            in_valid_i <= 1'b0;
         end else if (!(in_valid_i && !in_ready_o)) begin
            // a word that is offered stays until taken
            in_valid_i <= !gaps || (($urandom % 3) != 0);
            in_data_i  <= in_words[set * FRAME_IN_WORDS + sent];
         end
      end
   endtask

   task automatic check_frame(input string test, input int set, input bit rand_ready);
      int    got;
      int    idle;
      int    src;
      word_t expected;
      string name;
      got  = 0;
      idle = 0;
      while (got < FRAME_OUT_WORDS) begin
         @(posedge clk);
         if (out_valid_o && out_ready_i) begin
            src      = source_index(got);
            expected = (src < 0) ? '0 : in_words[set * FRAME_IN_WORDS + src];
            name     = $sformatf("%s word %0d", test, got);
            if (src < 0) begin
               check_value({name, " pad"}, 32'(0), 32'(out_word_o.data));
            end
            if (chk_word.exists(set * FRAME_OUT_WORDS + got)) begin
               check_value({name, " checkpoint"}, 32'(chk_word[set * FRAME_OUT_WORDS + got]),
                           32'(out_word_o.data));
            end
            check_value(name, 32'(expected), 32'(out_word_o.data));
            check_value({name, " last"}, 32'(got == FRAME_OUT_WORDS - 1),
                        32'(out_word_o.last));
            got++;
            idle = 0;
         end else begin
            idle++;
         end
         if (idle > 1000) begin
            report_timeout($sformatf("%s stalled after %0d output words", test, got));
         end
         out_ready_i <= !rand_ready || (($urandom % 2) == 1);
      end
   endtask

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////
   initial begin
      clk         = 1'b0;
      resetn      = 1'b0;
      in_valid_i  = 1'b0;
      in_data_i   = '0;
      out_ready_i = 1'b1;
      void'($urandom(32'h84b7));
      load_trace();
      check_value("trace input count", 32'(2 * FRAME_IN_WORDS), 32'(in_words.size()));
      check_value("trace has checkpoints", 32'(1), 32'(chk_word.num() > 0));

      repeat (3) @(posedge clk);
      resetn <= 1'b1;
      @(posedge clk);
      check_value("reset out_valid", 32'(0), 32'(out_valid_o));
      check_value("reset in_ready", 32'(1), 32'(in_ready_o));

      // full rate on both streams
      fork
         drive_frame(0, 1'b0);
         check_frame("full_rate", 0, 1'b0);
      join
      // second frame after restart with output stalls
      fork
         drive_frame(1, 1'b0);
         check_frame("random_ready", 1, 1'b1);
      join
      // gaps on the input stream
      fork
         drive_frame(0, 1'b1);
         check_frame("input_gaps", 0, 1'b0);
      join

      $display("** PASS **");
      $finish;
   end

endmodule

// ==== sliding_window_unit.sv ====
module sliding_window_unit
   import swu_pkg::*;
(
   input  logic      clk,
   input  logic      resetn,
   input  logic      in_valid_i,
   output logic      in_ready_o,
   input  word_t     in_data_i,
   output logic      out_valid_o,
   input  logic      out_ready_i,
   output out_word_t out_word_o
);

   logic [IN_IDX_W-1:0] wr_count;
   logic [IN_IDX_W-1:0] release_base;
   logic                rd_en;
   rd_req_t             rd_req;
   logic                rd_valid;
   out_word_t           rd_word;
   logic                accept;
   logic                frame_done;

   ////////////////////////////////////////
   // input side
   ////////////////////////////////////////
   window_buffer window_buffer_inst (
      .clk            (clk),
      .resetn         (resetn),
      .in_valid_i     (in_valid_i),
      .in_ready_o     (in_ready_o),
      .in_data_i      (in_data_i),
      .release_base_i (release_base),
      .rd_en_i        (rd_en),
      .rd_req_i       (rd_req),
      .frame_done_i   (frame_done),
      .wr_count_o     (wr_count),
      .rd_valid_o     (rd_valid),
      .rd_word_o      (rd_word)
   );

   window_addr_gen window_addr_gen_inst (
      .clk            (clk),
      .resetn         (resetn),
      .wr_count_i     (wr_count),
      .accept_i       (accept),
      .frame_done_i   (frame_done),
      .rd_en_o        (rd_en),
      .rd_req_o       (rd_req),
      .release_base_o (release_base)
   );

   ////////////////////////////////////////
   // output side
   ////////////////////////////////////////
   window_out_stage window_out_stage_inst (
      .clk          (clk),
      .resetn       (resetn),
      .rd_valid_i   (rd_valid),
      .rd_word_i    (rd_word),
      .out_ready_i  (out_ready_i),
      .out_valid_o  (out_valid_o),
      .out_word_o   (out_word_o),
      .accept_o     (accept),
      .frame_done_o (frame_done)
   );

endmodule

// ==== window_out_stage.sv ====
module window_out_stage
   import swu_pkg::*;
(
   input  logic      clk,
   input  logic      resetn,
   input  logic      rd_valid_i,
   input  out_word_t rd_word_i,
   input  logic      out_ready_i,
   output logic      out_valid_o,
   output out_word_t out_word_o,
   output logic      accept_o,
   output logic      frame_done_o
);

   logic                 out_fire;
   logic [OUT_CNT_W-1:0] out_cnt;

   assign accept_o     = !out_valid_o || out_ready_i;
   assign out_fire     = out_valid_o && out_ready_i;
   assign frame_done_o = out_fire && out_word_o.last;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         out_valid_o <= 1'b0;
      end else if (accept_o) begin
         out_valid_o <= rd_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (accept_o && rd_valid_i) begin
         out_word_o <= rd_word_i;
      end
   end

   // words taken so far in this frame
   always_ff @(posedge clk) begin
      if (!resetn || frame_done_o) begin
         out_cnt <= '0;
      end else if (out_fire) begin
         out_cnt <= out_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // protocol checks
   ////////////////////////////////////////
   a_hold_stable : assert property (
      @(posedge clk) disable iff (!resetn)
      (out_valid_o && !out_ready_i) |=> $stable(out_word_o)
   );

   // generator only issues when the read can land here next cycle
   a_no_drop : assert property (
      @(posedge clk) disable iff (!resetn)
      rd_valid_i |-> accept_o
   );

   a_last_position : assert property (
      @(posedge clk) disable iff (!resetn)
      out_fire |-> (out_word_o.last == (out_cnt == OUT_CNT_W'(FRAME_OUT_WORDS - 1)))
   );

endmodule

// ==== window_addr_gen.sv ====
module window_addr_gen
   import swu_pkg::*;
(
   input  logic                clk,
   input  logic                resetn,
   input  logic [IN_IDX_W-1:0] wr_count_i,
   input  logic                accept_i,
   input  logic                frame_done_i,
   output logic                rd_en_o,
   output rd_req_t             rd_req_o,
   output logic [IN_IDX_W-1:0] release_base_o
);

   gen_state_e state;

   logic [OX_W-1:0] ox;
   logic [OY_W-1:0] oy;
   logic [KW_W-1:0] kw;
   logic [KH_W-1:0] kh;
   logic [CH_W-1:0] ch;

   // read issued last cycle, its data sits in the read stage now
   logic rd_pending;

   int                  src_row;
   int                  src_col;
   int                  src_idx;
   int                  low_row;
   logic                pad;
   logic                is_last;
   logic                data_ok;
   logic [IN_IDX_W-1:0] rd_idx;

   ////////////////////////////////////////
   // source position of current window word
   ////////////////////////////////////////
   always_comb begin
      src_row = int'(oy) * STRIDE + int'(kh) - PAD;
      src_col = int'(ox) * STRIDE + int'(kw) - PAD;
      pad     = (src_row < 0) || (src_row >= IFM_H) ||
                (src_col < 0) || (src_col >= IFM_W);
      src_idx = (src_row * IFM_W + src_col) * CH_FOLDS + int'(ch);
   end

   assign rd_idx = pad ? '0 : src_idx[IN_IDX_W-1:0];

   // padded words go out without waiting for input
   assign data_ok = pad || (rd_idx < wr_count_i);

   assign is_last = (ox == OX_W'(OFM_W - 1)) && (oy == OY_W'(OFM_H - 1)) &&
                    (kh == KH_W'(K_H - 1)) && (kw == KW_W'(K_W - 1)) &&
                    (ch == CH_W'(CH_FOLDS - 1));

   // first input row still needed by this output row
   always_comb begin
      low_row = int'(oy) * STRIDE - PAD;
      if (low_row < 0) begin
         release_base_o = '0;
      end else begin
         release_base_o = IN_IDX_W'(low_row * ROW_WORDS);
      end
   end

   assign rd_en_o = (state == GEN_RUN) && accept_i && !rd_pending && data_ok;

   assign rd_req_o.addr = rd_idx[BUF_AW-1:0];
   assign rd_req_o.pad  = pad;
   assign rd_req_o.last = is_last;

   ////////////////////////////////////////
   // window walk, ch fastest and oy slowest
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         ox <= '0;
         oy <= '0;
         kw <= '0;
         kh <= '0;
         ch <= '0;
      end else if (rd_en_o) begin
         if (ch != CH_W'(CH_FOLDS - 1)) begin
            ch <= ch + 1'b1;
         end else begin
            ch <= '0;
            if (kw != KW_W'(K_W - 1)) begin
               kw <= kw + 1'b1;
            end else begin
               kw <= '0;
               if (kh != KH_W'(K_H - 1)) begin
                  kh <= kh + 1'b1;
               end else begin
                  kh <= '0;
                  if (ox != OX_W'(OFM_W - 1)) begin
                     ox <= ox + 1'b1;
                  end else begin
                     ox <= '0;
                     oy <= (oy == OY_W'(OFM_H - 1)) ? '0 : oy + 1'b1;
                  end
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         rd_pending <= 1'b0;
         state      <= GEN_RUN;
      end else begin
         rd_pending <= rd_en_o;
         unique case (state)
            GEN_RUN: begin
               if (rd_en_o && is_last) begin
                  state <= GEN_DRAIN;
               end
            end
            // last read moves into the output register
            GEN_DRAIN: begin
               if (accept_i) begin
                  state <= GEN_DONE;
               end
            end
            // wait for the last word to be taken downstream
            GEN_DONE: state <= GEN_DONE;
            default:  state <= GEN_RUN;
         endcase
      end
   end

   a_read_after_write : assert property (
      @(posedge clk) disable iff (!resetn)
      (rd_en_o && !rd_req_o.pad) |-> (rd_idx < wr_count_i)
   );

endmodule

// ==== window_buffer.sv ====
module window_buffer
   import swu_pkg::*;
(
   input  logic                clk,
   input  logic                resetn,
   input  logic                in_valid_i,
   output logic                in_ready_o,
   input  word_t               in_data_i,
   input  logic [IN_IDX_W-1:0] release_base_i,
   input  logic                rd_en_i,
   input  rd_req_t             rd_req_i,
   input  logic                frame_done_i,
   output logic [IN_IDX_W-1:0] wr_count_o,
   output logic                rd_valid_o,
   output out_word_t           rd_word_o
);

   word_t mem [BUF_DEPTH];

   logic                wr_fire;
   logic [IN_IDX_W:0]   release_limit;
   logic [BUF_AW-1:0]   wr_addr;

   ////////////////////////////////////////
   // write side
   ////////////////////////////////////////

   // highest index that may be written without clobbering a live row
   assign release_limit = {1'b0, release_base_i} + (IN_IDX_W + 1)'(BUF_DEPTH);

   assign in_ready_o = (wr_count_o < IN_IDX_W'(FRAME_IN_WORDS)) &&
                       ({1'b0, wr_count_o} < release_limit);

   assign wr_fire = in_valid_i && in_ready_o;

   // circular addressing, index modulo depth
   assign wr_addr = wr_count_o[BUF_AW-1:0];

   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         wr_count_o <= '0;
      end else if (wr_fire) begin
         wr_count_o <= wr_count_o + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_fire) begin
         mem[wr_addr] <= in_data_i;
      end
   end

   ////////////////////////////////////////
   // registered read port
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         rd_valid_o <= 1'b0;
      end else begin
         rd_valid_o <= rd_en_i;
      end
   end

   // padded positions need no stored data
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_word_o.data <= rd_req_i.pad ? '0 : mem[rd_req_i.addr];
         rd_word_o.last <= rd_req_i.last;
      end
   end

   // a write lands on index wr_count - BUF_DEPTH, which must already be released
   a_no_overwrite : assert property (
      @(posedge clk) disable iff (!resetn)
      wr_fire |-> ({1'b0, wr_count_o} < {1'b0, release_base_i} + (IN_IDX_W + 1)'(BUF_DEPTH))
   );

endmodule

// ==== swu_pkg.sv ====
package swu_pkg;

   ////////////////////////////////////////
   // map and kernel geometry
   ////////////////////////////////////////
   localparam int IFM_W    = 4;
   localparam int IFM_H    = 4;
   localparam int CHANNELS = 4;
   localparam int SIMD     = 2;
   localparam int CH_FOLDS = CHANNELS / SIMD;
   localparam int PREC     = 8;
   localparam int WORD_W   = SIMD * PREC;

   localparam int K_W    = 3;
   localparam int K_H    = 3;
   localparam int STRIDE = 1;
   localparam int PAD    = 1;

   localparam int OFM_W = (IFM_W + 2 * PAD - K_W) / STRIDE + 1;
   localparam int OFM_H = (IFM_H + 2 * PAD - K_H) / STRIDE + 1;

   // word counts per frame
   localparam int FRAME_IN_WORDS  = IFM_W * IFM_H * CH_FOLDS;
   localparam int FRAME_OUT_WORDS = OFM_W * OFM_H * K_W * K_H * CH_FOLDS;
   localparam int ROW_WORDS       = IFM_W * CH_FOLDS;

   // line buffer, must hold at least K_H rows
   localparam int BUF_DEPTH = 32;
   localparam int BUF_AW    = $clog2(BUF_DEPTH);
   localparam int IN_IDX_W  = $clog2(FRAME_IN_WORDS + 1);

   // window counter widths
   localparam int OX_W      = $clog2(OFM_W);
   localparam int OY_W      = $clog2(OFM_H);
   localparam int KW_W      = $clog2(K_W);
   localparam int KH_W      = $clog2(K_H);
   localparam int CH_W      = $clog2(CH_FOLDS);
   localparam int OUT_CNT_W = $clog2(FRAME_OUT_WORDS);

   ////////////////////////////////////////
   // shared types
   ////////////////////////////////////////
   typedef logic [WORD_W-1:0] word_t;

   typedef struct packed {
      logic [BUF_AW-1:0] addr;
      logic              pad;
      logic              last;
   } rd_req_t;

   typedef struct packed {
      word_t data;
      logic  last;
   } out_word_t;

   typedef enum logic [1:0] {
      GEN_RUN,
      GEN_DRAIN,
      GEN_DONE
   } gen_state_e;

endpackage
